// File: src/commit_pkg.sv
////////////////////////////////////////////////////////////
// Widths, depth and shared types of the commit stage.
// Every module refers to these by scoped name.
////////////////////////////////////////////////////////////

`default_nettype none

package commit_pkg;

    // Commit buffer geometry.
    localparam int num_entries = 8;
    localparam int idx_w = 3;

    // Datapath widths.
    localparam int pc_w = 64;
    localparam int data_w = 64;
    localparam int reg_addr_w = 5;

    // Writeback ports from the execution units.
    localparam int num_wb_ports = 3;

    typedef logic [pc_w-1:0] pc_t;

    typedef logic [data_w-1:0] data_t;

    typedef logic [reg_addr_w-1:0] reg_addr_t;

    typedef logic [idx_w-1:0] entry_idx_t;

    // One bit wider than an index so a full buffer is representable.
    typedef logic [idx_w:0] count_t;

    typedef enum logic {
        st_idle,   // Waiting for a complete head entry.
        st_write   // Register-file bus cycle in progress.
    } retire_state_e;

endpackage

`default_nettype wire

// File: src/dispatch_order.sv
////////////////////////////////////////////////////////////
// Puts the two dispatch slots into program order by PC.
// Valid slots are packed so the first allocation is the
// older instruction; purely combinational.
////////////////////////////////////////////////////////////

`default_nettype none

module dispatch_order (
    input  logic             disp0_valid,
    input  commit_pkg::pc_t  disp0_pc,
    input  logic             disp1_valid,
    input  commit_pkg::pc_t  disp1_pc,
    output logic [1:0]       alloc_count,
    output commit_pkg::pc_t  alloc_pc_first,
    output commit_pkg::pc_t  alloc_pc_second
);

    logic slot1_older;

    assign slot1_older = disp1_pc < disp0_pc;

    always_comb begin
        alloc_count = 2'd0;
        alloc_pc_first = '0;
        alloc_pc_second = '0;
        if (disp0_valid && disp1_valid) begin
            alloc_count = 2'd2;
            if (slot1_older) begin
                alloc_pc_first = disp1_pc;   // Lower PC retires first.
                alloc_pc_second = disp0_pc;
            end else begin
                alloc_pc_first = disp0_pc;
                alloc_pc_second = disp1_pc;
            end
        end else if (disp0_valid) begin
            alloc_count = 2'd1;
            alloc_pc_first = disp0_pc;
        end else if (disp1_valid) begin
            alloc_count = 2'd1;
            alloc_pc_first = disp1_pc;       // Lone slot 1 moves down.
        end
    end

endmodule

`default_nettype wire

// File: src/commit_buffer.sv
////////////////////////////////////////////////////////////
// Age-ordered commit buffer kept as a circular queue.
// Entries are allocated at the tail, completed by PC match
// on the writeback ports, and freed from the head on pop.
////////////////////////////////////////////////////////////

`default_nettype none

module commit_buffer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             alloc_count,
    input  commit_pkg::pc_t        alloc_pc_first,
    input  commit_pkg::pc_t        alloc_pc_second,
    input  commit_pkg::pc_t        wb0_pc,
    input  logic                   wb0_wen,
    input  commit_pkg::reg_addr_t  wb0_addr,
    input  commit_pkg::data_t      wb0_data,
    input  commit_pkg::pc_t        wb1_pc,
    input  logic                   wb1_wen,
    input  commit_pkg::reg_addr_t  wb1_addr,
    input  commit_pkg::data_t      wb1_data,
    input  commit_pkg::pc_t        wb2_pc,
    input  logic                   wb2_wen,
    input  commit_pkg::reg_addr_t  wb2_addr,
    input  commit_pkg::data_t      wb2_data,
    input  logic                   pop,
    output logic                   dispatch_ready,
    output logic                   head_ready,
    output logic                   head_wen,
    output commit_pkg::reg_addr_t  head_addr,
    output commit_pkg::data_t      head_data
);

    // Entry storage.
    commit_pkg::pc_t        ent_pc   [commit_pkg::num_entries];
    commit_pkg::reg_addr_t  ent_addr [commit_pkg::num_entries];
    commit_pkg::data_t      ent_data [commit_pkg::num_entries];
    logic                   ent_wen  [commit_pkg::num_entries];
    logic [commit_pkg::num_entries-1:0] ent_occ;
    logic [commit_pkg::num_entries-1:0] ent_done;

    commit_pkg::entry_idx_t head;
    commit_pkg::entry_idx_t tail;
    commit_pkg::entry_idx_t tail_next;
    commit_pkg::count_t     count;
    logic [1:0]             n_alloc;

    // Writeback ports gathered for the match loop.
    commit_pkg::pc_t        wb_pc   [commit_pkg::num_wb_ports];
    logic                   wb_wen  [commit_pkg::num_wb_ports];
    commit_pkg::reg_addr_t  wb_addr [commit_pkg::num_wb_ports];
    commit_pkg::data_t      wb_data [commit_pkg::num_wb_ports];

    // Per-entry result selected from the matching port.
    logic [commit_pkg::num_entries-1:0] hit;
    logic                   hit_wen  [commit_pkg::num_entries];
    commit_pkg::reg_addr_t  hit_addr [commit_pkg::num_entries];
    commit_pkg::data_t      hit_data [commit_pkg::num_entries];

    assign wb_pc[0] = wb0_pc;
    assign wb_pc[1] = wb1_pc;
    assign wb_pc[2] = wb2_pc;
    assign wb_wen[0] = wb0_wen;
    assign wb_wen[1] = wb1_wen;
    assign wb_wen[2] = wb2_wen;
    assign wb_addr[0] = wb0_addr;
    assign wb_addr[1] = wb1_addr;
    assign wb_addr[2] = wb2_addr;
    assign wb_data[0] = wb0_data;
    assign wb_data[1] = wb1_data;
    assign wb_data[2] = wb2_data;

    // Two free slots needed, pop of this cycle not counted.
    assign dispatch_ready = count <= commit_pkg::count_t'(commit_pkg::num_entries - 2);
    assign n_alloc = dispatch_ready ? alloc_count : 2'd0;
    assign tail_next = tail + commit_pkg::entry_idx_t'(1);

    assign head_ready = ent_occ[head] & ent_done[head];
    assign head_wen = ent_wen[head];
    assign head_addr = ent_addr[head];
    assign head_data = ent_data[head];

    always_comb begin
        for (int i = 0; i < commit_pkg::num_entries; i++) begin
            hit[i] = 1'b0;
            hit_wen[i] = 1'b0;
            hit_addr[i] = '0;
            hit_data[i] = '0;
            // Ascending port order, so the later port wins a tie.
            for (int p = 0; p < commit_pkg::num_wb_ports; p++) begin
                if (wb_pc[p] != '0 && ent_occ[i] && ent_pc[i] == wb_pc[p]) begin
                    hit[i] = 1'b1;
                    hit_wen[i] = wb_wen[p];
                    hit_addr[i] = wb_addr[p];
                    hit_data[i] = wb_data[p];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
            ent_occ <= '0;
            ent_done <= '0;
        end else begin
            ent_done <= ent_done | hit;
            if (pop) begin
                ent_occ[head] <= 1'b0;
                ent_done[head] <= 1'b0;
                head <= head + commit_pkg::entry_idx_t'(1);
            end
            if (n_alloc != 2'd0) begin
                ent_occ[tail] <= 1'b1;
                ent_done[tail] <= 1'b0;
            end
            if (n_alloc == 2'd2) begin
                ent_occ[tail_next] <= 1'b1;
                ent_done[tail_next] <= 1'b0;
            end
            tail <= tail + commit_pkg::entry_idx_t'(n_alloc);
            count <= count + commit_pkg::count_t'(n_alloc) - commit_pkg::count_t'(pop);
        end
    end

    // Payload; only meaningful while the entry is occupied.
    always_ff @(posedge clk) begin
        for (int i = 0; i < commit_pkg::num_entries; i++) begin
            if (hit[i]) begin
                ent_wen[i] <= hit_wen[i];
                ent_addr[i] <= hit_addr[i];
                ent_data[i] <= hit_data[i];
            end
        end
        if (n_alloc != 2'd0) begin
            ent_pc[tail] <= alloc_pc_first;
        end
        if (n_alloc == 2'd2) begin
            ent_pc[tail_next] <= alloc_pc_second;
        end
    end

endmodule

`default_nettype wire

// File: src/retire_wb_master.sv
////////////////////////////////////////////////////////////
// Retires the complete head entry. A register write goes
// out as a Wishbone classic cycle held until ack; entries
// without a write are popped at once.
////////////////////////////////////////////////////////////

`default_nettype none

module retire_wb_master (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   head_ready,
    input  logic                   head_wen,
    input  commit_pkg::reg_addr_t  head_addr,
    input  commit_pkg::data_t      head_data,
    output logic                   pop,
    output logic                   rf_cyc,
    output logic                   rf_stb,
    output logic                   rf_we,
    output commit_pkg::reg_addr_t  rf_adr,
    output commit_pkg::data_t      rf_dat,
    input  logic                   rf_ack
);

    commit_pkg::retire_state_e state;
    logic start_write;
    logic silent_pop;

    assign start_write = (state == commit_pkg::st_idle) && head_ready && head_wen;
    assign silent_pop = (state == commit_pkg::st_idle) && head_ready && !head_wen;

    assign pop = silent_pop || ((state == commit_pkg::st_write) && rf_ack);

    // Bus strobes come straight from the state register.
    assign rf_cyc = state == commit_pkg::st_write;
    assign rf_stb = state == commit_pkg::st_write;
    assign rf_we = state == commit_pkg::st_write;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= commit_pkg::st_idle;
        end else begin
            case (state)
                commit_pkg::st_idle: begin
                    if (start_write) begin
                        state <= commit_pkg::st_write;
                    end
                end
                commit_pkg::st_write: begin
                    if (rf_ack) begin
                        state <= commit_pkg::st_idle;   // Cycle ends next clock.
                    end
                end
                default: begin
                    state <= commit_pkg::st_idle;
                end
            endcase
        end
    end

    // Address and data held stable for the whole bus cycle.
    always_ff @(posedge clk) begin
        if (start_write) begin
            rf_adr <= head_addr;
            rf_dat <= head_data;
        end
    end

endmodule

`default_nettype wire

// File: src/commit_top.sv
////////////////////////////////////////////////////////////
// Commit stage top level. Dispatch ordering feeds the
// commit buffer, whose head is retired over Wishbone.
////////////////////////////////////////////////////////////

`default_nettype none

module commit_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   disp0_valid,
    input  commit_pkg::pc_t        disp0_pc,
    input  logic                   disp1_valid,
    input  commit_pkg::pc_t        disp1_pc,
    input  commit_pkg::pc_t        wb0_pc,
    input  logic                   wb0_wen,
    input  commit_pkg::reg_addr_t  wb0_addr,
    input  commit_pkg::data_t      wb0_data,
    input  commit_pkg::pc_t        wb1_pc,
    input  logic                   wb1_wen,
    input  commit_pkg::reg_addr_t  wb1_addr,
    input  commit_pkg::data_t      wb1_data,
    input  commit_pkg::pc_t        wb2_pc,
    input  logic                   wb2_wen,
    input  commit_pkg::reg_addr_t  wb2_addr,
    input  commit_pkg::data_t      wb2_data,
    output logic                   dispatch_ready,
    output logic                   rf_cyc,
    output logic                   rf_stb,
    output logic                   rf_we,
    output commit_pkg::reg_addr_t  rf_adr,
    output commit_pkg::data_t      rf_dat,
    input  logic                   rf_ack
);

    logic [1:0]             alloc_count;
    commit_pkg::pc_t        alloc_pc_first;
    commit_pkg::pc_t        alloc_pc_second;
    logic                   head_ready;
    logic                   head_wen;
    commit_pkg::reg_addr_t  head_addr;
    commit_pkg::data_t      head_data;
    logic                   pop;

    dispatch_order i_dispatch_order (
        .disp0_valid     (disp0_valid),
        .disp0_pc        (disp0_pc),
        .disp1_valid     (disp1_valid),
        .disp1_pc        (disp1_pc),
        .alloc_count     (alloc_count),
        .alloc_pc_first  (alloc_pc_first),
        .alloc_pc_second (alloc_pc_second)
    );

    commit_buffer i_commit_buffer (
        .clk             (clk),
        .rst             (rst),
        .alloc_count     (alloc_count),
        .alloc_pc_first  (alloc_pc_first),
        .alloc_pc_second (alloc_pc_second),
        .wb0_pc          (wb0_pc),
        .wb0_wen         (wb0_wen),
        .wb0_addr        (wb0_addr),
        .wb0_data        (wb0_data),
        .wb1_pc          (wb1_pc),
        .wb1_wen         (wb1_wen),
        .wb1_addr        (wb1_addr),
        .wb1_data        (wb1_data),
        .wb2_pc          (wb2_pc),
        .wb2_wen         (wb2_wen),
        .wb2_addr        (wb2_addr),
        .wb2_data        (wb2_data),
        .pop             (pop),
        .dispatch_ready  (dispatch_ready),
        .head_ready      (head_ready),
        .head_wen        (head_wen),
        .head_addr       (head_addr),
        .head_data       (head_data)
    );

    retire_wb_master i_retire_wb_master (
        .clk        (clk),
        .rst        (rst),
        .head_ready (head_ready),
        .head_wen   (head_wen),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .pop        (pop),
        .rf_cyc     (rf_cyc),
        .rf_stb     (rf_stb),
        .rf_we      (rf_we),
        .rf_adr     (rf_adr),
        .rf_dat     (rf_dat),
        .rf_ack     (rf_ack)
    );

endmodule

`default_nettype wire

// File: test/commit_assertions.sv
////////////////////////////////////////////////////////////
// Wishbone master and reset checks on the commit stage.
// Bound to commit_top below.
////////////////////////////////////////////////////////////

`default_nettype none

module commit_assertions (
    input logic                   clk,
    input logic                   rst,
    input logic                   dispatch_ready,
    input logic                   rf_cyc,
    input logic                   rf_stb,
    input logic                   rf_ack,
    input commit_pkg::reg_addr_t  rf_adr,
    input commit_pkg::data_t      rf_dat
);

    timeunit 1ns;
    timeprecision 1ps;

    // Strobe and cycle held together until the slave acks.
    stb_held_until_ack: assert property (@(posedge clk) disable iff (rst)
        rf_stb && !rf_ack |=> rf_stb && rf_cyc)
        else $error("rf_stb or rf_cyc dropped before rf_ack");

    // Address and data frozen until the slave acks.
    bus_stable: assert property (@(posedge clk) disable iff (rst)
        rf_stb && !rf_ack |=> $stable(rf_adr) && $stable(rf_dat))
        else $error("rf_adr or rf_dat changed during an unacked strobe");

    ready_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> dispatch_ready)
        else $error("dispatch_ready low during reset");

endmodule

bind commit_top commit_assertions i_commit_assertions (
    .clk            (clk),
    .rst            (rst),
    .dispatch_ready (dispatch_ready),
    .rf_cyc         (rf_cyc),
    .rf_stb         (rf_stb),
    .rf_ack         (rf_ack),
    .rf_adr         (rf_adr),
    .rf_dat         (rf_dat)
);

`default_nettype wire

// File: test/commit_tb.sv
////////////////////////////////////////////////////////////
// Testbench for the commit stage. Random dispatch and
// completion traffic, a Wishbone slave with random ack
// delay, and an in-order check of every register write.
////////////////////////////////////////////////////////////

`default_nettype none

module commit_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 200;

    logic                   clk;
    logic                   rst;
    logic                   disp0_valid;
    commit_pkg::pc_t        disp0_pc;
    logic                   disp1_valid;
    commit_pkg::pc_t        disp1_pc;
    commit_pkg::pc_t        wb_pc   [commit_pkg::num_wb_ports];
    logic                   wb_wen  [commit_pkg::num_wb_ports];
    commit_pkg::reg_addr_t  wb_addr [commit_pkg::num_wb_ports];
    commit_pkg::data_t      wb_data [commit_pkg::num_wb_ports];
    logic                   dispatch_ready;
    logic                   rf_cyc;
    logic                   rf_stb;
    logic                   rf_we;
    commit_pkg::reg_addr_t  rf_adr;
    commit_pkg::data_t      rf_dat;
    logic                   rf_ack;

    // Issued instructions and the result each one completes with.
    commit_pkg::pc_t        iss_pc   [$];
    logic                   iss_wen  [$];
    commit_pkg::reg_addr_t  iss_addr [$];
    commit_pkg::data_t      iss_data [$];
    commit_pkg::pc_t        next_pc;
    commit_pkg::pc_t        last_write_pc = '0;
    int                     ack_delay [64];
    int                     seed;
    int                     writes_seen = 0;
    int                     writes_expected;
    int                     write_errors = 0;
    int                     state_errors;
    int                     timeouts;
    logic                   ack_hold;

    commit_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .disp0_valid    (disp0_valid),
        .disp0_pc       (disp0_pc),
        .disp1_valid    (disp1_valid),
        .disp1_pc       (disp1_pc),
        .wb0_pc         (wb_pc[0]),
        .wb0_wen        (wb_wen[0]),
        .wb0_addr       (wb_addr[0]),
        .wb0_data       (wb_data[0]),
        .wb1_pc         (wb_pc[1]),
        .wb1_wen        (wb_wen[1]),
        .wb1_addr       (wb_addr[1]),
        .wb1_data       (wb_data[1]),
        .wb2_pc         (wb_pc[2]),
        .wb2_wen        (wb_wen[2]),
        .wb2_addr       (wb_addr[2]),
        .wb2_data       (wb_data[2]),
        .dispatch_ready (dispatch_ready),
        .rf_cyc         (rf_cyc),
        .rf_stb         (rf_stb),
        .rf_we          (rf_we),
        .rf_adr         (rf_adr),
        .rf_dat         (rf_dat),
        .rf_ack         (rf_ack)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic clear_wb();
        for (int p = 0; p < commit_pkg::num_wb_ports; p++) begin
            wb_pc[p] = '0;   // PC zero marks an idle port.
            wb_wen[p] = 1'b0;
            wb_addr[p] = '0;
            wb_data[p] = '0;
        end
    endtask

    // Next write in program order is the lowest PC above the last write that has wen set.
    function automatic int next_write_idx(commit_pkg::pc_t after_pc);
        int best;
        best = -1;
        for (int i = 0; i < iss_pc.size(); i++) begin
            if (iss_wen[i] && iss_pc[i] > after_pc && (best < 0 || iss_pc[i] < iss_pc[best])) begin
                best = i;
            end
        end
        return best;
    endfunction

    always @(negedge clk) begin : compare_writes
        int idx;
        if (!rst && rf_cyc && rf_stb && rf_ack) begin
            idx = next_write_idx(last_write_pc);
            assert (idx >= 0) else begin
                write_errors++;
                $display("[FAIL] %0d ns: unexpected write of %h to x%0d", $time, rf_dat, rf_adr);
            end
            if (idx >= 0) begin
                assert (rf_we && rf_adr == iss_addr[idx] && rf_dat == iss_data[idx]) else begin
                    write_errors++;
                    $display("[FAIL] %0d ns: pc %h wrote x%0d = %h, expected x%0d = %h",
                             $time, iss_pc[idx], rf_adr, rf_dat, iss_addr[idx], iss_data[idx]);
                end
                last_write_pc = iss_pc[idx];
            end
            writes_seen++;
        end
    end

    initial begin : wb_slave
        int wait_left;
        int n_acks;
        rf_ack = 1'b0;
        wait_left = 0;
        n_acks = 0;
        forever begin
            @(posedge clk);
            #2;
            if (rf_ack) begin
                rf_ack = 1'b0;   // Ack was taken at this edge.
                n_acks++;
                wait_left = ack_delay[n_acks % 64];
            end else if (rf_stb && !ack_hold) begin
                if (wait_left == 0) begin
                    rf_ack = 1'b1;
                end else begin
                    wait_left--;
                end
            end
        end
    end

    task automatic wait_dispatch_ready();
        int cycles;
        cycles = 0;
        while (!dispatch_ready && cycles < timeout_cycles) begin
            step();
            cycles++;
        end
        if (!dispatch_ready) begin
            timeouts++;
            $display("Timeout: dispatch_ready stayed low for %0d cycles", timeout_cycles);
        end
    endtask

    task automatic drain_writes();
        int cycles;
        cycles = 0;
        while (writes_seen < writes_expected && cycles < timeout_cycles) begin
            step();
            cycles++;
        end
        if (writes_seen < writes_expected) begin
            timeouts++;
            $display("Timeout: only %0d of %0d register writes seen", writes_seen, writes_expected);
        end
    endtask

    // Wen modes: 0 random, 1 all write, 2 first half silent.
    task automatic issue_batch(input int n, input bit paired, input bit swap_slots,
                               input int wen_mode, output int base);
        int k;
        logic wen;
        logic [31:0] rnd_hi;
        logic [31:0] rnd_lo;
        base = iss_pc.size();
        for (int i = 0; i < n; i++) begin
            wen = (wen_mode == 1) || (wen_mode == 2 && i >= n / 2)
                || (wen_mode == 0 && $random(seed) % 2 != 0);
            rnd_hi = $random(seed);
            rnd_lo = $random(seed);
            iss_pc.push_back(next_pc);
            iss_wen.push_back(wen);
            iss_addr.push_back(commit_pkg::reg_addr_t'($random(seed)));
            iss_data.push_back({rnd_hi, rnd_lo});
            if (wen) begin
                writes_expected++;
            end
            next_pc += 64'd4;
        end
        k = base;
        while (k < base + n) begin
            wait_dispatch_ready();
            if (paired && k + 1 < base + n) begin
                disp0_valid = 1'b1;
                disp1_valid = 1'b1;
                disp0_pc = swap_slots ? iss_pc[k + 1] : iss_pc[k];
                disp1_pc = swap_slots ? iss_pc[k] : iss_pc[k + 1];
                k += 2;
            end else begin
                disp1_valid = swap_slots;   // Lone slot 1 also allocates.
                disp0_valid = !swap_slots;
                disp0_pc = swap_slots ? '0 : iss_pc[k];
                disp1_pc = swap_slots ? iss_pc[k] : '0;
                k++;
            end
            step();
            disp0_valid = 1'b0;
            disp1_valid = 1'b0;
        end
    endtask

    task automatic complete_batch(input int base, input int n, input bit shuffle);
        int order [$];
        int j;
        int tmp;
        int per_cycle;
        int rot;
        for (int i = 0; i < n; i++) begin
            order.push_back(base + i);
        end
        for (int i = n - 1; i > 0 && shuffle; i--) begin
            j = $unsigned($random(seed)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        while (order.size() > 0) begin
            per_cycle = shuffle ? 1 + $unsigned($random(seed)) % 3 : 1;
            rot = $unsigned($random(seed)) % 3;
            for (int p = 0; p < per_cycle && order.size() > 0; p++) begin
                j = order.pop_front();
                wb_pc[(p + rot) % 3] = iss_pc[j];
                wb_wen[(p + rot) % 3] = iss_wen[j];
                wb_addr[(p + rot) % 3] = iss_addr[j];
                wb_data[(p + rot) % 3] = iss_data[j];
            end
            step();
            clear_wb();
        end
    endtask

    initial begin
        int base;
        int seen_before;
        seed = 32'h36fb;
        for (int i = 0; i < 64; i++) begin
            ack_delay[i] = $unsigned($random(seed)) % 4;
        end
        rst = 1'b1;
        disp0_valid = 1'b0;
        disp0_pc = '0;
        disp1_valid = 1'b0;
        disp1_pc = '0;
        clear_wb();
        next_pc = 64'h8000_0000;
        writes_expected = 0;
        state_errors = 0;
        timeouts = 0;
        ack_hold = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst = 1'b0;
        assert (!rf_cyc && !rf_stb && dispatch_ready) else begin
            state_errors++;
            $display("[FAIL] %0d ns: bus active or dispatch_ready low after reset", $time);
        end
        repeat (5) step();
        assert (writes_seen == 0) else begin
            state_errors++;
            $display("[FAIL] %0d ns: register write without any dispatch", $time);
        end

        issue_batch(6, 1'b0, 1'b0, 1, base);
        complete_batch(base, 6, 1'b0);
        drain_writes();
        repeat (4) begin
            issue_batch(6, 1'b0, 1'b0, 0, base);
            complete_batch(base, 6, 1'b1);
            drain_writes();
        end
        repeat (3) begin
            issue_batch(5, 1'b1, 1'b1, 0, base);   // Older instruction sits in slot 1.
            complete_batch(base, 5, 1'b1);
            drain_writes();
        end
        issue_batch(6, 1'b0, 1'b0, 2, base);
        complete_batch(base, 6, 1'b0);
        drain_writes();

        ack_hold = 1'b1;
        seen_before = writes_seen;
        issue_batch(8, 1'b1, 1'b0, 1, base);
        assert (!dispatch_ready) else begin
            state_errors++;
            $display("[FAIL] %0d ns: dispatch_ready high with the buffer full", $time);
        end
        disp0_valid = 1'b1;   // Must be ignored while not ready.
        disp0_pc = 64'h0bad_0000;
        step();
        disp0_valid = 1'b0;
        complete_batch(base, 8, 1'b1);
        repeat (10) step();
        assert (rf_stb && writes_seen == seen_before) else begin
            state_errors++;
            $display("[FAIL] %0d ns: retirement did not stall without ack", $time);
        end
        ack_hold = 1'b0;
        drain_writes();
        repeat (3) begin
            issue_batch(6, 1'b1, 1'b0, 0, base);
            complete_batch(base, 6, 1'b1);
            drain_writes();
        end

        $display("Writes seen %0d of %0d, write errors %0d, state errors %0d, timeouts %0d",
                 writes_seen, writes_expected, write_errors, state_errors, timeouts);
        if (write_errors == 0 && state_errors == 0 && timeouts == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/commit_pkg.sv
src/dispatch_order.sv
src/commit_buffer.sv
src/retire_wb_master.sv
src/commit_top.sv
test/commit_assertions.sv
test/commit_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compiles the commit stage testbench with Verilator and runs it.

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "Cannot enter the project directory"
    exit 1
fi

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module commit_tb -Mdir obj_dir -f files.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vcommit_tb)"
sim_status=$?
echo "$output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
fi

if echo "$output" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1
